// ==== bench/preload_input.txt ====
# op addr data err, all hex; W = APB write (err expected), R = APB read (data and err expected)
# F = start the fetch over the current window and check stream, status and checksum
W 0040 13579bdf 0
W 0044 2468ace0 0
W 0048 0badf00d 0
W 004c 11223344 0
W 0050 55667788 0
W 0054 99aabbcc 0
W 0058 ddeeff00 0
W 005c 7f00ff01 0
W 0400 a5a5a5a5 0
W 0404 5a5a5a5a 0
W 0408 00000001 0
W 040c 80000000 0
W 0ffc cafef00d 0
R 0040 13579bdf 0
R 0050 55667788 0
R 005c 7f00ff01 0
R 040c 80000000 0
R 0ffc cafef00d 0
W 1004 00000010 0
W 1008 00000017 0
R 1004 00000010 0
R 1008 00000017 0
W 100c ffffffff 1
W 1010 12345678 1
W 1014 00000001 1
R 1014 00000000 1
R 1800 00000000 1
R 100c 00000000 0
R 1010 00000000 0
R 1004 00000010 0
F
R 100c 00000002 0
W 1004 00000103 0
W 1008 00000100 0
F
W 1004 000003ff 0
W 1008 000003ff 0
F
W 1000 00000002 0
R 100c 00000006 0
W 0044 deadbeef 1
R 0044 2468ace0 0
W 1004 00000010 0
W 1008 00000017 0
F
R 1000 00000002 0

// ==== all.f ====
logic/preload_pkg.sv
logic/mem_port_if.sv
logic/boot_ctrl_if.sv
logic/boot_regs.sv
logic/boot_sram.sv
logic/fetch_engine.sv
logic/preload_top.sv
bench/tb_preload.sv

// ==== Bender.yml ====
package:
  name: preload

sources:
  - logic/preload_pkg.sv
  - logic/mem_port_if.sv
  - logic/boot_ctrl_if.sv
  - logic/boot_regs.sv
  - logic/boot_sram.sv
  - logic/fetch_engine.sv
  - logic/preload_top.sv
  - target: test
    files:
      - bench/tb_preload.sv

// ==== bench/tb_preload.sv ====
// ==========================================================
// Testbench for the preload subsystem: APB driver, stimulus
// reader, SRAM reference model and fetch stream monitor
// ==========================================================
`timescale 1ns/1ps

module tb_preload;
   import preload_pkg::*;

   localparam int PreadyTimeout = 20;
   localparam int DonePolls     = 100;

   logic  clk_sys = 1'b0;
   logic  rst_n;
   logic  psel;
   logic  penable;
   logic  pwrite;
   addr_t paddr;
   word_t pwdata;
   word_t prdata;
   logic  pready;
   logic  pslverr;
   logic  fetch_valid;
   word_t fetch_data;
   widx_t fetch_idx;
   logic  fetch_ready;

   integer seed = 32'hbcdd;
   integer rnd;
   int     err_count = 0;
   int     timeout_count = 0;

   // Reference model of the SRAM image and the control registers
   word_t  model_mem [SramWords];
   logic   model_lock = 1'b0;
   int     model_start = 0;
   int     model_end = 0;

   // Stream monitor state
   logic   stream_open = 1'b0;
   int     exp_idx;
   int     xfer_count;

   preload_top dut0 (
      .clk_sys       (clk_sys),
      .rst_n_i       (rst_n),
      .psel_i        (psel),
      .penable_i     (penable),
      .pwrite_i      (pwrite),
      .paddr_i       (paddr),
      .pwdata_i      (pwdata),
      .prdata_o      (prdata),
      .pready_o      (pready),
      .pslverr_o     (pslverr),
      .fetch_valid_o (fetch_valid),
      .fetch_data_o  (fetch_data),
      .fetch_idx_o   (fetch_idx),
      .fetch_ready_i (fetch_ready)
   );

   always #4 clk_sys = ~clk_sys;

   // Random back-pressure, ready about three cycles in four
   always @(posedge clk_sys) begin
      if (rst_n) begin
         rnd = $random(seed);
         fetch_ready <= (rnd[1:0] != 2'b00);
      end
   end

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
         err_count++;
      end
   endtask

   // Handshakes are sampled on the falling edge, where valid and ready are settled
   always @(negedge clk_sys) begin
      if (rst_n && fetch_valid && fetch_ready) begin
         if (!stream_open || exp_idx > model_end) begin
            $display("A fetch word was transferred outside the fetch window at %0t ns", $time);
            err_count++;
         end else begin
            check_value("fetch_idx_o", exp_idx, fetch_idx);
            check_value("fetch_data_o", model_mem[exp_idx], fetch_data);
         end
         exp_idx++;
         xfer_count++;
      end
   end

   task automatic apb_xfer(input logic wr, input addr_t addr, input word_t wdata,
                           output word_t rdata, output logic err);
      int waited;
      waited = 0;
      @(posedge clk_sys);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk_sys);
      penable <= 1'b1;
      @(negedge clk_sys);
      while (!pready && waited < PreadyTimeout) begin
         @(negedge clk_sys);
         waited++;
      end
      if (!pready) begin
         $display("APB transfer to address %h never completed", addr);
         timeout_count++;
      end
      rdata = prdata;
      err   = pslverr;
      @(posedge clk_sys);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // Applies the address map rules, so refused writes never reach the model
   task automatic model_write(input addr_t addr, input word_t data);
      roff_t off;
      off = roff_t'(addr - RegBase);
      if (addr < RegBase) begin
         if (!model_lock) begin
            model_mem[addr[11:2]] = data;
         end
      end else if (off == RegCtrl && data[1]) begin
         model_lock = 1'b1;
      end else if (off == RegStart) begin
         model_start = data[9:0];
      end else if (off == RegEnd) begin
         model_end = data[9:0];
      end
   endtask

   task automatic run_fetch();
      word_t rdata;
      word_t exp_sum;
      logic  err;
      logic  done_seen;
      int    polls;
      int    exp_count;
      exp_sum   = '0;
      exp_count = (model_end >= model_start) ? model_end - model_start + 1 : 0;
      for (int i = model_start; i <= model_end; i++) begin
         exp_sum ^= model_mem[i];
      end
      exp_idx     = model_start;
      xfer_count  = 0;
      stream_open = 1'b1;
      apb_xfer(1'b1, RegBase + RegCtrl, 32'h1, rdata, err);
      check_value("pslverr_o", 0, err);
      done_seen = 1'b0;
      polls     = 0;
      while (!done_seen && polls < DonePolls) begin
         apb_xfer(1'b0, RegBase + RegStatus, '0, rdata, err);
         done_seen = rdata[1];
         polls++;
      end
      stream_open = 1'b0;
      if (!done_seen) begin
         $display("Fetch engine did not report done in time");
         timeout_count++;
      end
      check_value("fetch word count", exp_count, xfer_count);
      check_value("RegStatus", {29'b0, model_lock, 2'b10}, rdata);
      apb_xfer(1'b0, RegBase + RegChecksum, '0, rdata, err);
      check_value("RegChecksum", exp_sum, rdata);
   endtask

   task automatic run_line(input string line);
      byte         op;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] err_exp;
      word_t       rdata;
      logic        err;
      int          n;
      n = $sscanf(line, "%c %h %h %h", op, addr, data, err_exp);
      // Reads and writes need address, data and error fields
      if (op != "F" && n != 4) begin
         $display("Stimulus line is missing fields: %s", line);
         err_count++;
      end else begin
         case (op)
            "W": begin
               apb_xfer(1'b1, addr_t'(addr), data, rdata, err);
               check_value("pslverr_o", err_exp, err);
               model_write(addr_t'(addr), data);
            end
            "R": begin
               apb_xfer(1'b0, addr_t'(addr), '0, rdata, err);
               check_value("pslverr_o", err_exp, err);
               if (!err_exp[0]) begin
                  check_value("prdata_o", data, rdata);
               end
            end
            "F": run_fetch();
            default: begin
               $display("Unknown operation in stimulus line: %s", line);
               err_count++;
            end
         endcase
      end
   endtask

   initial begin
      int    fd;
      int    n;
      string line;
      rst_n       = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      fetch_ready = 1'b0;
      repeat (16) @(posedge clk_sys);
      rst_n <= 1'b1;
      @(negedge clk_sys);
      check_value("pready_o", 1, pready);
      check_value("pslverr_o", 0, pslverr);
      check_value("fetch_valid_o", 0, fetch_valid);
      fd = $fopen("bench/preload_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file");
         err_count++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line[0] != "#" && line[0] != "\n") begin
               run_line(line);
            end
         end
         $fclose(fd);
      end
      $display("Checks failed: %0d, timeouts: %0d", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== logic/preload_top.sv ====
// ==========================================================
// Preload subsystem top, APB target and fetch stream ports
// ==========================================================
`timescale 1ns/1ps

module preload_top (
   input  logic                clk_sys,
   input  logic                rst_n_i,
   // APB target
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pwrite_i,
   input  preload_pkg::addr_t  paddr_i,
   input  preload_pkg::word_t  pwdata_i,
   output preload_pkg::word_t  prdata_o,
   output logic                pready_o,
   output logic                pslverr_o,
   // Fetch stream
   output logic                fetch_valid_o,
   output preload_pkg::word_t  fetch_data_o,
   output preload_pkg::widx_t  fetch_idx_o,
   input  logic                fetch_ready_i
);

   // SRAM ports for the APB side and the fetch side
   mem_port_if host_port ();
   mem_port_if fetch_port ();

   boot_ctrl_if boot_ctrl ();

   boot_regs u_boot_regs (
      .clk_sys   (clk_sys),
      .rst_n_i   (rst_n_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .mem_o     (host_port.requester),
      .ctrl_o    (boot_ctrl.ctrl)
   );

   boot_sram u_boot_sram (
      .clk_sys (clk_sys),
      .host_i  (host_port.memory),
      .fetch_i (fetch_port.memory)
   );

   fetch_engine u_fetch_engine (
      .clk_sys       (clk_sys),
      .rst_n_i       (rst_n_i),
      .mem_o         (fetch_port.requester),
      .ctrl_i        (boot_ctrl.engine),
      .fetch_valid_o (fetch_valid_o),
      .fetch_data_o  (fetch_data_o),
      .fetch_idx_o   (fetch_idx_o),
      .fetch_ready_i (fetch_ready_i)
   );

endmodule

// ==== logic/fetch_engine.sv ====
// ==========================================================
// Fetch window reader with valid/ready output and checksum
// ==========================================================
`timescale 1ns/1ps

module fetch_engine (
   input  logic                clk_sys,
   input  logic                rst_n_i,
   mem_port_if.requester       mem_o,
   boot_ctrl_if.engine         ctrl_i,
   output logic                fetch_valid_o,
   output preload_pkg::word_t  fetch_data_o,
   output preload_pkg::widx_t  fetch_idx_o,
   input  logic                fetch_ready_i
);
   import preload_pkg::*;

   fetch_state_t state_q;
   widx_t        idx_q;
   widx_t        end_q;
   word_t        data_q;
   word_t        checksum_q;
   logic         done_q;
   logic         launch;
   logic         empty_win;
   logic         handshake;
   logic         last_word;

   assign launch    = (state_q == Idle) && ctrl_i.start;
   assign empty_win = ctrl_i.end_idx < ctrl_i.start_idx;
   assign handshake = fetch_valid_o && fetch_ready_i;
   assign last_word = idx_q == end_q;

   // Each read goes out one cycle before Read, so data is there on entry
   assign mem_o.req   = (launch && !empty_win) || (handshake && !last_word);
   assign mem_o.idx   = (state_q == Idle) ? ctrl_i.start_idx : idx_q + 1'b1;
   assign mem_o.we    = 1'b0;
   assign mem_o.wdata = '0;

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= Idle;
         idx_q      <= '0;
         end_q      <= '0;
         checksum_q <= '0;
         done_q     <= 1'b0;
      end else begin
         case (state_q)
            Idle: begin
               // Window is latched so later register writes do not disturb it
               if (launch) begin
                  idx_q      <= ctrl_i.start_idx;
                  end_q      <= ctrl_i.end_idx;
                  checksum_q <= '0;
                  done_q     <= 1'b0;
                  state_q    <= empty_win ? Finish : Read;
               end
            end
            Read: state_q <= Hold;
            Hold: begin
               if (fetch_ready_i) begin
                  checksum_q <= checksum_q ^ data_q;
                  if (last_word) begin
                     done_q  <= 1'b1;
                     state_q <= Idle;
                  end else begin
                     idx_q   <= idx_q + 1'b1;
                     state_q <= Read;
                  end
               end
            end
            Finish: begin
               done_q  <= 1'b1;
               state_q <= Idle;
            end
            default: state_q <= Idle;
         endcase
      end
   end

   always_ff @(posedge clk_sys) begin
      if (state_q == Read) begin
         data_q <= mem_o.rdata;
      end
   end

   assign fetch_valid_o   = state_q == Hold;
   assign fetch_data_o    = data_q;
   assign fetch_idx_o     = idx_q;
   assign ctrl_i.busy     = state_q != Idle;
   assign ctrl_i.done     = done_q;
   assign ctrl_i.checksum = checksum_q;

   a_hold_stable: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      (fetch_valid_o && !fetch_ready_i) |=>
      (fetch_valid_o && $stable(fetch_data_o) && $stable(fetch_idx_o)))
      else $error("Fetch output changed under back-pressure");

   // A word on the stream belongs to a fetch that has not yet reported done
   a_valid_busy: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      fetch_valid_o |-> (ctrl_i.busy && !ctrl_i.done))
      else $error("Fetch valid while engine idle or done");

endmodule

// ==== logic/boot_sram.sv ====
// ==========================================================
// Dual-port boot memory, host port and read-only fetch port
// ==========================================================
`timescale 1ns/1ps

module boot_sram (
   input  logic        clk_sys,
   mem_port_if.memory  host_i,
   mem_port_if.memory  fetch_i
);
   import preload_pkg::*;

   word_t mem_q [SramWords];
   logic  host_wr;
   logic  same_word;

   assign host_wr   = host_i.req && host_i.we;
   assign same_word = host_i.idx == fetch_i.idx;

   always_ff @(posedge clk_sys) begin
      if (host_wr) begin
         mem_q[host_i.idx] <= host_i.wdata;
      end
   end

   // Host port, write-first
   always_ff @(posedge clk_sys) begin
      if (host_i.req) begin
         if (host_i.we) begin
            host_i.rdata <= host_i.wdata;
         end else begin
            host_i.rdata <= mem_q[host_i.idx];
         end
      end
   end

   // Fetch port sees a host write to the same word in the same cycle
   always_ff @(posedge clk_sys) begin
      if (fetch_i.req) begin
         if (host_wr && same_word) begin
            fetch_i.rdata <= host_i.wdata;
         end else begin
            fetch_i.rdata <= mem_q[fetch_i.idx];
         end
      end
   end

   a_fetch_read_only: assert property (@(posedge clk_sys)
      !fetch_i.we)
      else $error("Write request on the fetch port");

endmodule

// ==== logic/boot_regs.sv ====
// ==========================================================
// APB target with address decode, control registers and
// SRAM forwarding under the lock rule
// ==========================================================
`timescale 1ns/1ps

module boot_regs (
   input  logic                clk_sys,
   input  logic                rst_n_i,
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pwrite_i,
   input  preload_pkg::addr_t  paddr_i,
   input  preload_pkg::word_t  pwdata_i,
   output preload_pkg::word_t  prdata_o,
   output logic                pready_o,
   output logic                pslverr_o,
   mem_port_if.requester       mem_o,
   boot_ctrl_if.ctrl           ctrl_o
);
   import preload_pkg::*;

   logic  apb_access;
   logic  sram_sel;
   roff_t reg_off;
   logic  reg_mapped;
   logic  reg_ro;
   logic  acc_err;
   logic  sram_rd;
   logic  wr_ok;
   logic  ctrl_wr;
   logic  rd_wait_q;
   logic  lock_q;
   widx_t start_q;
   widx_t end_q;
   word_t reg_rdata;

   assign apb_access = psel_i && penable_i;
   assign sram_sel   = paddr_i < RegBase;
   assign reg_off    = roff_t'(paddr_i - RegBase);

   always_comb begin
      reg_mapped = 1'b1;
      reg_ro     = 1'b0;
      reg_rdata  = '0;
      case (reg_off)
         RegCtrl:     reg_rdata = word_t'({lock_q, 1'b0});
         RegStart:    reg_rdata = word_t'(start_q);
         RegEnd:      reg_rdata = word_t'(end_q);
         RegStatus: begin
            reg_ro    = 1'b1;
            reg_rdata = word_t'({lock_q, ctrl_o.done, ctrl_o.busy});
         end
         RegChecksum: begin
            reg_ro    = 1'b1;
            reg_rdata = ctrl_o.checksum;
         end
         default:     reg_mapped = 1'b0;
      endcase
   end

   // Locked SRAM and read-only or unknown registers refuse the access
   assign acc_err = sram_sel ? (pwrite_i && lock_q) :
                               (!reg_mapped || (pwrite_i && reg_ro));

   assign sram_rd = apb_access && sram_sel && !pwrite_i;
   assign wr_ok   = apb_access && pwrite_i && !acc_err;
   assign ctrl_wr = wr_ok && !sram_sel && (reg_off == RegCtrl);

   // SRAM reads wait one access cycle for the registered read port
   assign pready_o  = !(sram_rd && !rd_wait_q);
   assign pslverr_o = apb_access && acc_err;
   assign prdata_o  = rd_wait_q ? mem_o.rdata : reg_rdata;

   assign mem_o.req   = (sram_rd && !rd_wait_q) || (wr_ok && sram_sel);
   assign mem_o.we    = wr_ok && sram_sel;
   assign mem_o.idx   = paddr_i[IdxWidth+1:2];
   assign mem_o.wdata = pwdata_i;

   assign ctrl_o.start     = ctrl_wr && pwdata_i[CtrlStartBit];
   assign ctrl_o.start_idx = start_q;
   assign ctrl_o.end_idx   = end_q;

   always_ff @(posedge clk_sys or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rd_wait_q <= 1'b0;
         lock_q    <= 1'b0;
         start_q   <= '0;
         end_q     <= '0;
      end else begin
         rd_wait_q <= sram_rd && !rd_wait_q;
         // Lock stays set until reset
         if (ctrl_wr && pwdata_i[CtrlLockBit]) begin
            lock_q <= 1'b1;
         end
         if (wr_ok && !sram_sel && (reg_off == RegStart)) begin
            start_q <= pwdata_i[IdxWidth-1:0];
         end
         if (wr_ok && !sram_sel && (reg_off == RegEnd)) begin
            end_q <= pwdata_i[IdxWidth-1:0];
         end
      end
   end

   a_penable_psel: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      penable_i |-> psel_i)
      else $error("APB penable high without psel");

   // Once lock has been seen, it must stay set and block every SRAM write
   a_locked_write: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
      $past(lock_q) |-> (lock_q && !(mem_o.req && mem_o.we)))
      else $error("SRAM write issued while locked");

endmodule

// ==== logic/boot_ctrl_if.sv ====
// ==========================================================
// Control link between boot registers and fetch engine
// ==========================================================
`timescale 1ns/1ps

interface boot_ctrl_if;
   import preload_pkg::*;

   // One-cycle pulse
   logic  start;
   widx_t start_idx;
   widx_t end_idx;
   logic  busy;
   logic  done;
   word_t checksum;

   modport ctrl (
      output start,
      output start_idx,
      output end_idx,
      input  busy,
      input  done,
      input  checksum
   );

   modport engine (
      input  start,
      input  start_idx,
      input  end_idx,
      output busy,
      output done,
      output checksum
   );

endinterface

// ==== logic/mem_port_if.sv ====
// ==========================================================
// One synchronous SRAM port, requester and memory sides
// ==========================================================
`timescale 1ns/1ps

interface mem_port_if;
   import preload_pkg::*;

   logic  req;
   logic  we;
   widx_t idx;
   word_t wdata;
   // Valid the cycle after req
   word_t rdata;

   modport requester (
      output req,
      output we,
      output idx,
      output wdata,
      input  rdata
   );

   modport memory (
      input  req,
      input  we,
      input  idx,
      input  wdata,
      output rdata
   );

endinterface

// ==== logic/preload_pkg.sv ====
// ==========================================================
// Address map, bus widths, word types and fetch FSM states
// ==========================================================
package preload_pkg;

   // Bus and memory widths
   localparam int unsigned AddrWidth = 13;
   localparam int unsigned DataWidth = 32;
   localparam int unsigned IdxWidth  = 10;
   localparam int unsigned OffWidth  = 12;
   localparam int unsigned SramWords = 1024;

   typedef logic [AddrWidth-1:0] addr_t;
   typedef logic [DataWidth-1:0] word_t;
   typedef logic [IdxWidth-1:0]  widx_t;
   // Byte offset inside the register window
   typedef logic [OffWidth-1:0]  roff_t;

   // Everything below RegBase is boot SRAM
   localparam addr_t RegBase = 13'h1000;

   // Register offsets from RegBase
   localparam roff_t RegCtrl     = 12'h000;
   localparam roff_t RegStart    = 12'h004;
   localparam roff_t RegEnd      = 12'h008;
   localparam roff_t RegStatus   = 12'h00C;
   localparam roff_t RegChecksum = 12'h010;

   // RegCtrl bits
   localparam int unsigned CtrlStartBit = 0;
   localparam int unsigned CtrlLockBit  = 1;

   // Fetch engine FSM
   typedef enum logic [1:0] {
      Idle,
      Read,
      Hold,
      Finish
   } fetch_state_t;

endpackage
